// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+.
issue_pkg.sv
issue_ifs.sv
regfile.sv
fu_status_table.sv
issue_select.sv
issue_stage.sv
issue_stage_tb.sv

// ==== fu_status_table.sv ====
/* functional unit status table */

`timescale 1ns/10ps
`default_nettype none

`include "issue_defs.svh"

module fu_status_table (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       dispatch_en,
    input  logic [`ISSUE_FU_IDX_W-1:0] dispatch_fu,
    input  issue_pkg::fust_row_t       dispatch_row,
    input  logic [`ISSUE_NUM_FU-1:0]   fu_done,
    input  logic                       branch_miss,
    input  logic                       freeze,
    output logic [`ISSUE_NUM_FU-1:0]   busy,
    fust_if.tbl                        tbl
);

    localparam int NFU = `ISSUE_NUM_FU;
    localparam int TW  = `ISSUE_TAG_W;
    localparam int FW  = `ISSUE_FU_IDX_W;
    localparam int AW  = `ISSUE_AGE_W;
    localparam logic [AW-1:0] AGE_MAX = '1;

    issue_pkg::fust_state_e [NFU-1:0] state;
    issue_pkg::fust_state_e [NFU-1:0] state_n;
    issue_pkg::fust_row_t   [NFU-1:0] row;
    issue_pkg::fust_row_t   [NFU-1:0] row_n;
    logic [NFU-1:0][AW-1:0]           age;
    logic [NFU-1:0][AW-1:0]           age_n;
    // slot takes the dispatched row at this edge
    logic [NFU-1:0]                   take;
    // executing row retires at this edge
    logic [NFU-1:0]                   frees;
    logic                             accepted;

    // clear a tag whose producing unit signals done
    function automatic logic [TW-1:0] wake(
        input logic [TW-1:0]  tag,
        input logic [NFU-1:0] done
    );
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < NFU; j++) begin
            if (done[j] && tag == TW'(j + 1)) begin
                hit = 1'b1;
            end
        end
        return hit ? '0 : tag;
    endfunction

    // dispatch acceptance
    // a slot is free when empty or when its op retires now
    // index 3 never matches a slot
    always_comb begin
        for (int i = 0; i < NFU; i++) begin
            frees[i] = (state[i] == issue_pkg::FUST_EX) && fu_done[i];
            take[i]  = dispatch_en && (dispatch_fu == FW'(i))
                       && ((state[i] == issue_pkg::FUST_EMPTY) || frees[i]);
        end
        accepted = |take;
    end

    // per-row next state, payload and age
    always_comb begin
        state_n = state;
        row_n   = row;
        age_n   = age;
        for (int i = 0; i < NFU; i++) begin
            // resident tags drop as producers finish
            row_n[i].t1 = wake(row[i].t1, fu_done);
            row_n[i].t2 = wake(row[i].t2, fu_done);

            case (state[i])
                issue_pkg::FUST_EMPTY: begin
                    if (take[i]) begin
                        state_n[i] = issue_pkg::FUST_WAIT;
                    end
                end
                issue_pkg::FUST_WAIT: begin
                    // both operands available
                    if (row[i].t1 == '0 && row[i].t2 == '0) begin
                        state_n[i] = issue_pkg::FUST_RDY;
                    end
                end
                issue_pkg::FUST_RDY: begin
                    // no recheck, the grant only names ready rows
                    if (tbl.grant[i]) begin
                        state_n[i] = issue_pkg::FUST_EX;
                    end
                end
                issue_pkg::FUST_EX: begin
                    // back-to-back dispatch refills the slot directly
                    if (frees[i]) begin
                        state_n[i] = take[i] ? issue_pkg::FUST_WAIT
                                             : issue_pkg::FUST_EMPTY;
                    end
                end
                default: begin
                    state_n[i] = issue_pkg::FUST_EMPTY;
                end
            endcase

            if (take[i]) begin
                // incoming row also sees same-cycle completions
                row_n[i]    = dispatch_row;
                row_n[i].t1 = wake(dispatch_row.t1, fu_done);
                row_n[i].t2 = wake(dispatch_row.t2, fu_done);
                age_n[i]    = AW'(1);
            end else if (state_n[i] == issue_pkg::FUST_EMPTY) begin
                age_n[i] = '0;
            end else if (accepted && age[i] != AGE_MAX) begin
                // everyone already here gets older
                age_n[i] = age[i] + 1'b1;
            end
        end
    end

    // control state, held on freeze, emptied on a miss
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NFU; i++) begin
                state[i] <= issue_pkg::FUST_EMPTY;
                age[i]   <= '0;
            end
        end else if (!freeze) begin
            if (branch_miss) begin
                for (int i = 0; i < NFU; i++) begin
                    state[i] <= issue_pkg::FUST_EMPTY;
                    age[i]   <= '0;
                end
            end else begin
                state <= state_n;
                age   <= age_n;
            end
        end
    end

    // row payload
    always_ff @(posedge CLK) begin
        if (!freeze) begin
            row <= row_n;
        end
    end

    always_comb begin
        for (int i = 0; i < NFU; i++) begin
            busy[i] = (state[i] != issue_pkg::FUST_EMPTY);
        end
    end

    assign tbl.state = state;
    assign tbl.row   = row;
    assign tbl.age   = age;

endmodule

`default_nettype wire

// ==== issue_defs.svh ====
/* issue stage widths and counts */

`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// register file data word
`define ISSUE_WORD_W 32

// architectural register index
`define ISSUE_REG_ADDR_W 5

// scalar units, 0 alu, 1 load/store, 2 branch
`define ISSUE_NUM_FU 3

// wide enough to name any unit, index 3 is unused
`define ISSUE_FU_IDX_W 2

// source tag, 0 means operand ready
// j+1 means operand still produced by unit j
`define ISSUE_TAG_W 2

// age counter, saturates at its top value
`define ISSUE_AGE_W 2

// opcode field carried through to the units
`define ISSUE_OP_W 4

`endif

// ==== issue_ifs.sv ====
/* issue stage internal interfaces */

`timescale 1ns/10ps
`default_nettype none

`include "issue_defs.svh"

// register file ports, one write and two reads
interface regfile_if;

    // write side, fed from writeback
    logic                         wen;
    logic [`ISSUE_REG_ADDR_W-1:0] wsel;
    logic [`ISSUE_WORD_W-1:0]     wdata;

    // read side, addressed by the issue selector
    logic [`ISSUE_REG_ADDR_W-1:0] rsel1;
    logic [`ISSUE_REG_ADDR_W-1:0] rsel2;
    logic [`ISSUE_WORD_W-1:0]     rdat1;
    logic [`ISSUE_WORD_W-1:0]     rdat2;

    // register file itself
    modport rf (
        input  wen, wsel, wdata, rsel1, rsel2,
        output rdat1, rdat2
    );

    // operand reader
    modport rd (
        output rsel1, rsel2,
        input  rdat1, rdat2
    );

endinterface

// status table contents toward the selector, grant back
interface fust_if;

    issue_pkg::fust_state_e [`ISSUE_NUM_FU-1:0]       state;
    issue_pkg::fust_row_t   [`ISSUE_NUM_FU-1:0]       row;
    logic [`ISSUE_NUM_FU-1:0][`ISSUE_AGE_W-1:0]       age;
    // one-hot or zero, only ever names a ready row
    logic [`ISSUE_NUM_FU-1:0]                         grant;

    // status table side
    modport tbl (
        output state, row, age,
        input  grant
    );

    // arbiter side
    modport sel (
        input  state, row, age,
        output grant
    );

endinterface

`default_nettype wire

// ==== issue_pkg.sv ====
/* issue stage types */

`default_nettype none

`include "issue_defs.svh"

package issue_pkg;

    // lifecycle of one unit's status row
    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    // one dispatched scalar operation
    typedef struct packed {
        // opcode as decoded by dispatch
        logic [`ISSUE_OP_W-1:0]       op;
        // source and destination registers
        logic [`ISSUE_REG_ADDR_W-1:0] rs1;
        logic [`ISSUE_REG_ADDR_W-1:0] rs2;
        logic [`ISSUE_REG_ADDR_W-1:0] rd;
        // immediate, used as operand 2 when i_type is set
        logic [`ISSUE_WORD_W-1:0]     imm;
        logic                         i_type;
        // producer tags for rs1 and rs2
        logic [`ISSUE_TAG_W-1:0]      t1;
        logic [`ISSUE_TAG_W-1:0]      t2;
    } fust_row_t;

endpackage

`default_nettype wire

// ==== issue_select.sv ====
/* oldest-ready issue selector */

`timescale 1ns/10ps
`default_nettype none

`include "issue_defs.svh"

module issue_select (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         freeze,
    input  logic                         branch_miss,
    fust_if.sel                          sel,
    regfile_if.rd                        rd,
    output logic                         out_valid,
    output logic [`ISSUE_NUM_FU-1:0]     out_fu_en,
    output logic [`ISSUE_OP_W-1:0]       out_op,
    output logic [`ISSUE_REG_ADDR_W-1:0] out_rd,
    output logic [`ISSUE_WORD_W-1:0]     out_rdat1,
    output logic [`ISSUE_WORD_W-1:0]     out_rdat2
);

    localparam int NFU = `ISSUE_NUM_FU;
    localparam int FW  = `ISSUE_FU_IDX_W;

    logic                     found;
    logic [FW-1:0]            win;
    logic [`ISSUE_AGE_W-1:0]  win_age;
    logic [NFU-1:0]           grant;
    issue_pkg::fust_row_t     win_row;
    logic [`ISSUE_WORD_W-1:0] op2;

    // oldest ready row wins
    // strict compare keeps the lowest index on a tie
    always_comb begin
        found   = 1'b0;
        win     = '0;
        win_age = '0;
        for (int i = 0; i < NFU; i++) begin
            if (sel.state[i] == issue_pkg::FUST_RDY
                && (!found || sel.age[i] > win_age)) begin
                found   = 1'b1;
                win     = FW'(i);
                win_age = sel.age[i];
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[win] = 1'b1;
        end
    end

    assign sel.grant = grant;

    // operand read for the winner
    assign win_row  = sel.row[win];
    assign rd.rsel1 = win_row.rs1;
    assign rd.rsel2 = win_row.rs2;
    // immediate forms replace the second register operand
    assign op2 = win_row.i_type ? win_row.imm : rd.rdat2;

    // issue valid and unit enable
    // one cycle per grant, freeze wins over a miss
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_valid <= 1'b0;
            out_fu_en <= '0;
        end else if (!freeze) begin
            if (branch_miss) begin
                out_valid <= 1'b0;
                out_fu_en <= '0;
            end else begin
                out_valid <= found;
                out_fu_en <= grant;
            end
        end
    end

    // issue payload, only loaded when something issues
    always_ff @(posedge CLK) begin
        if (!freeze && found) begin
            out_op    <= win_row.op;
            out_rd    <= win_row.rd;
            out_rdat1 <= rd.rdat1;
            out_rdat2 <= op2;
        end
    end

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
/* operand issue stage */

`timescale 1ns/10ps
`default_nettype none

`include "issue_defs.svh"

module issue_stage (
    input  logic                         CLK,
    input  logic                         nRST,
    // dispatch
    input  logic                         dispatch_en,
    input  logic [`ISSUE_FU_IDX_W-1:0]   dispatch_fu,
    input  logic [`ISSUE_OP_W-1:0]       dispatch_op,
    input  logic [`ISSUE_REG_ADDR_W-1:0] dispatch_rs1,
    input  logic [`ISSUE_REG_ADDR_W-1:0] dispatch_rs2,
    input  logic [`ISSUE_REG_ADDR_W-1:0] dispatch_rd,
    input  logic [`ISSUE_WORD_W-1:0]     dispatch_imm,
    input  logic                         dispatch_i_type,
    input  logic [`ISSUE_TAG_W-1:0]      dispatch_t1,
    input  logic [`ISSUE_TAG_W-1:0]      dispatch_t2,
    // completion and writeback
    input  logic [`ISSUE_NUM_FU-1:0]     fu_done,
    input  logic                         wb_en,
    input  logic [`ISSUE_REG_ADDR_W-1:0] wb_sel,
    input  logic [`ISSUE_WORD_W-1:0]     wb_data,
    // pipeline control
    input  logic                         branch_miss,
    input  logic                         freeze,
    // status and issue word
    output logic [`ISSUE_NUM_FU-1:0]     busy,
    output logic                         out_valid,
    output logic [`ISSUE_NUM_FU-1:0]     out_fu_en,
    output logic [`ISSUE_OP_W-1:0]       out_op,
    output logic [`ISSUE_REG_ADDR_W-1:0] out_rd,
    output logic [`ISSUE_WORD_W-1:0]     out_rdat1,
    output logic [`ISSUE_WORD_W-1:0]     out_rdat2
);

    regfile_if            rfif ();
    fust_if               fif ();
    issue_pkg::fust_row_t disp_row;

    // gather the dispatch fields into one row
    always_comb begin
        disp_row.op     = dispatch_op;
        disp_row.rs1    = dispatch_rs1;
        disp_row.rs2    = dispatch_rs2;
        disp_row.rd     = dispatch_rd;
        disp_row.imm    = dispatch_imm;
        disp_row.i_type = dispatch_i_type;
        disp_row.t1     = dispatch_t1;
        disp_row.t2     = dispatch_t2;
    end

    // writeback goes straight in, freeze does not stop it
    assign rfif.wen   = wb_en;
    assign rfif.wsel  = wb_sel;
    assign rfif.wdata = wb_data;

    regfile u_rf (
        .CLK (CLK),
        .nRST(nRST),
        .rf  (rfif.rf)
    );

    fu_status_table u_table (
        .CLK         (CLK),
        .nRST        (nRST),
        .dispatch_en (dispatch_en),
        .dispatch_fu (dispatch_fu),
        .dispatch_row(disp_row),
        .fu_done     (fu_done),
        .branch_miss (branch_miss),
        .freeze      (freeze),
        .busy        (busy),
        .tbl         (fif.tbl)
    );

    // table and register file feed the selector side by side
    issue_select u_select (
        .CLK        (CLK),
        .nRST       (nRST),
        .freeze     (freeze),
        .branch_miss(branch_miss),
        .sel        (fif.sel),
        .rd         (rfif.rd),
        .out_valid  (out_valid),
        .out_fu_en  (out_fu_en),
        .out_op     (out_op),
        .out_rd     (out_rd),
        .out_rdat1  (out_rdat1),
        .out_rdat2  (out_rdat2)
    );

endmodule

`default_nettype wire

// ==== issue_stage_tb.sv ====
/* issue stage testbench */

`timescale 1ns/10ps
`default_nettype none

`include "issue_defs.svh"

module issue_stage_tb;

    localparam int NFU     = `ISSUE_NUM_FU;
    localparam int NREGS   = 1 << `ISSUE_REG_ADDR_W;
    localparam int AGE_TOP = (1 << `ISSUE_AGE_W) - 1;
    localparam int SEED    = 32'hbcdb;
    localparam int HALF    = 2;
    // cycle budget per test, reset first
    localparam int TEST_LEN = 2 + 6 + 20 + 6 + 20 + 16 + 28;
    localparam int LIMIT    = 2 * TEST_LEN;

    logic                         CLK;
    logic                         nRST;
    logic                         dispatch_en;
    logic [`ISSUE_FU_IDX_W-1:0]   dispatch_fu;
    logic [`ISSUE_OP_W-1:0]       dispatch_op;
    logic [`ISSUE_REG_ADDR_W-1:0] dispatch_rs1;
    logic [`ISSUE_REG_ADDR_W-1:0] dispatch_rs2;
    logic [`ISSUE_REG_ADDR_W-1:0] dispatch_rd;
    logic [`ISSUE_WORD_W-1:0]     dispatch_imm;
    logic                         dispatch_i_type;
    logic [`ISSUE_TAG_W-1:0]      dispatch_t1;
    logic [`ISSUE_TAG_W-1:0]      dispatch_t2;
    logic [NFU-1:0]               fu_done;
    logic                         wb_en;
    logic [`ISSUE_REG_ADDR_W-1:0] wb_sel;
    logic [`ISSUE_WORD_W-1:0]     wb_data;
    logic                         branch_miss;
    logic                         freeze;
    logic [NFU-1:0]               busy;
    logic                         out_valid;
    logic [NFU-1:0]               out_fu_en;
    logic [`ISSUE_OP_W-1:0]       out_op;
    logic [`ISSUE_REG_ADDR_W-1:0] out_rd;
    logic [`ISSUE_WORD_W-1:0]     out_rdat1;
    logic [`ISSUE_WORD_W-1:0]     out_rdat2;

    // shadow of the architectural registers
    logic [`ISSUE_WORD_W-1:0]     shadow [NREGS];
    // expected row per unit, recorded at dispatch
    logic [`ISSUE_OP_W-1:0]       slot_op [NFU];
    logic [`ISSUE_REG_ADDR_W-1:0] slot_rs1 [NFU];
    logic [`ISSUE_REG_ADDR_W-1:0] slot_rs2 [NFU];
    logic [`ISSUE_REG_ADDR_W-1:0] slot_rd [NFU];
    logic [`ISSUE_WORD_W-1:0]     slot_imm [NFU];
    logic                         slot_it [NFU];
    // occupancy and age as dispatch order implies
    logic [NFU-1:0]               model_busy;
    int                           model_age [NFU];
    int                           errors = 0;
    int                           prop_errors = 0;
    int                           checks = 0;
    int                           cycles = 0;

    issue_stage uut (.*);

    initial CLK = 1'b0;
    always #HALF CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // at most one unit enabled, valid agrees with it
    issue_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(out_fu_en) && (out_valid == (out_fu_en != '0)))
    else begin
        prop_errors++;
        $display("ERROR %0t ns: out_fu_en %b with out_valid %b", $time,
                 $sampled(out_fu_en), $sampled(out_valid));
    end

    task automatic tick();
        @(negedge CLK);
    endtask

    task automatic expect_val(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input logic exp_valid);
        expect_val(32'(busy), 32'(model_busy), "busy");
        expect_val(32'(out_valid), 32'(exp_valid), "out_valid");
    endtask

    // writeback port, x0 keeps zero in the shadow
    task automatic write_reg(input logic [4:0] sel, input logic [31:0] data);
        wb_en   = 1'b1;
        wb_sel  = sel;
        wb_data = data;
        if (sel != 5'd0) begin
            shadow[sel] = data;
        end
        tick();
        wb_en = 1'b0;
    endtask

    task automatic dispatch(
        input int          fu,
        input logic [3:0]  op,
        input logic [4:0]  rs1, rs2, rd,
        input logic [31:0] imm,
        input logic        i_type,
        input logic [1:0]  t1, t2
    );
        dispatch_en     = 1'b1;
        dispatch_fu     = 2'(fu);
        dispatch_op     = op;
        dispatch_rs1    = rs1;
        dispatch_rs2    = rs2;
        dispatch_rd     = rd;
        dispatch_imm    = imm;
        dispatch_i_type = i_type;
        dispatch_t1     = t1;
        dispatch_t2     = t2;
        // residents age, the newcomer starts at one
        for (int j = 0; j < NFU; j++) begin
            if (model_busy[j] && model_age[j] < AGE_TOP) begin
                model_age[j]++;
            end
        end
        model_busy[fu] = 1'b1;
        model_age[fu]  = 1;
        slot_op[fu]    = op;
        slot_rs1[fu]   = rs1;
        slot_rs2[fu]   = rs2;
        slot_rd[fu]    = rd;
        slot_imm[fu]   = imm;
        slot_it[fu]    = i_type;
        tick();
        dispatch_en = 1'b0;
    endtask

    // completion pulse for one unit
    task automatic retire(input int fu);
        fu_done     = '0;
        fu_done[fu] = 1'b1;
        model_busy[fu] = 1'b0;
        model_age[fu]  = 0;
        tick();
        fu_done = '0;
    endtask

    task automatic flush();
        branch_miss = 1'b1;
        model_busy  = '0;
        for (int j = 0; j < NFU; j++) begin
            model_age[j] = 0;
        end
        tick();
        branch_miss = 1'b0;
    endtask

    task automatic wait_issue(input string what);
        int n;
        n = 0;
        while (!out_valid && n < 12) begin
            tick();
            n++;
        end
        checks++;
        assert (out_valid)
        else begin
            errors++;
            $display("%s: nothing issued within %0d cycles", what, n);
        end
    endtask

    // issue word against the recorded row and the shadow registers
    task automatic check_issue(input int fu);
        logic [31:0] exp2;
        exp2 = slot_it[fu] ? slot_imm[fu] : shadow[slot_rs2[fu]];
        expect_val(32'(out_fu_en), 32'(1 << fu), "out_fu_en");
        expect_val(32'(out_op), 32'(slot_op[fu]), "out_op");
        expect_val(32'(out_rd), 32'(slot_rd[fu]), "out_rd");
        expect_val(out_rdat1, shadow[slot_rs1[fu]], "out_rdat1");
        expect_val(out_rdat2, exp2, "out_rdat2");
    endtask

    // oldest candidate, lowest index on a tie
    function automatic int oldest_of(input logic [NFU-1:0] cand);
        int best;
        best = -1;
        for (int j = 0; j < NFU; j++) begin
            if (cand[j] && (best < 0 || model_age[j] > model_age[best])) begin
                best = j;
            end
        end
        return best;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(31, 1));
    endfunction

    task automatic report_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors + prop_errors);
    endtask

    initial begin
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] v;
        int          first;
        void'($urandom(SEED));
        dispatch_en     = 1'b0;
        dispatch_fu     = '0;
        dispatch_op     = '0;
        dispatch_rs1    = '0;
        dispatch_rs2    = '0;
        dispatch_rd     = '0;
        dispatch_imm    = '0;
        dispatch_i_type = 1'b0;
        dispatch_t1     = '0;
        dispatch_t2     = '0;
        fu_done         = '0;
        wb_en           = 1'b0;
        wb_sel          = '0;
        wb_data         = '0;
        branch_miss     = 1'b0;
        freeze          = 1'b0;
        model_busy      = '0;
        for (int i = 0; i < NREGS; i++) begin
            shadow[i] = '0;
        end
        for (int j = 0; j < NFU; j++) begin
            model_age[j] = 0;
        end
        nRST = 1'b0;
        repeat (2) tick();
        nRST = 1'b1;

        // idle after reset
        for (int k = 0; k < 6; k++) begin
            check_status(1'b0);
            tick();
        end
        report_test("reset idle");

        // alu issue two cycles after dispatch
        for (int k = 0; k < 8; k++) begin
            write_reg(pick_reg(), $urandom);
        end
        write_reg(5'd0, 32'hdeadbeef);
        ra = pick_reg();
        rb = pick_reg();
        dispatch(0, 4'h3, ra, rb, 5'd7, 32'h0, 1'b0, 2'd0, 2'd0);
        check_status(1'b0);
        tick();
        check_status(1'b0);
        tick();
        check_status(1'b1);
        check_issue(0);
        retire(0);
        // rs1 written in the grant cycle, rs2 is x0
        ra = pick_reg();
        v  = $urandom;
        dispatch(0, 4'h5, ra, 5'd0, 5'd9, 32'h0, 1'b0, 2'd0, 2'd0);
        tick();
        check_status(1'b0);
        write_reg(ra, v);
        check_status(1'b1);
        check_issue(0);
        retire(0);
        report_test("alu issue and bypass");

        // immediate replaces operand 2
        ra = pick_reg();
        dispatch(2, 4'h9, ra, pick_reg(), 5'd3, $urandom, 1'b1, 2'd0, 2'd0);
        wait_issue("immediate row");
        check_issue(2);
        retire(2);
        report_test("immediate");

        // alu row waits on load/store
        dispatch(1, 4'h2, pick_reg(), pick_reg(), 5'd4, 32'h0, 1'b0, 2'd0, 2'd0);
        wait_issue("load/store row");
        check_issue(1);
        dispatch(0, 4'h1, pick_reg(), pick_reg(), 5'd5, 32'h0, 1'b0, 2'd2, 2'd0);
        for (int k = 0; k < 6; k++) begin
            check_status(1'b0);
            tick();
        end
        retire(1);
        check_status(1'b0);
        wait_issue("woken alu row");
        check_issue(0);
        retire(0);
        report_test("tag wakeup");

        // two waiters released by one branch completion
        dispatch(2, 4'h6, pick_reg(), pick_reg(), 5'd8, 32'h0, 1'b0, 2'd0, 2'd0);
        wait_issue("branch producer");
        check_issue(2);
        dispatch(1, 4'h7, pick_reg(), pick_reg(), 5'd10, 32'h0, 1'b0, 2'd3, 2'd0);
        dispatch(0, 4'h8, pick_reg(), pick_reg(), 5'd11, 32'h0, 1'b0, 2'd0, 2'd3);
        first = oldest_of(3'b011);
        retire(2);
        wait_issue("older waiter");
        check_issue(first);
        tick();
        wait_issue("younger waiter");
        check_issue(1 - first);
        retire(0);
        retire(1);
        report_test("oldest first");

        // freeze holds the issue word and busy
        dispatch(0, 4'hA, pick_reg(), pick_reg(), 5'd12, 32'h0, 1'b0, 2'd0, 2'd0);
        wait_issue("row before freeze");
        check_issue(0);
        freeze = 1'b1;
        // a dispatch under freeze is dropped
        dispatch_en = 1'b1;
        dispatch_fu = 2'd1;
        for (int k = 0; k < 3; k++) begin
            tick();
            check_status(1'b1);
        end
        dispatch_en = 1'b0;
        freeze      = 1'b0;
        tick();
        check_status(1'b0);
        retire(0);
        // branch miss empties the table and drops the pending grant
        dispatch(1, 4'hB, pick_reg(), pick_reg(), 5'd13, 32'h0, 1'b0, 2'd3, 2'd0);
        dispatch(0, 4'hC, pick_reg(), pick_reg(), 5'd14, 32'h0, 1'b0, 2'd0, 2'd0);
        tick();
        // alu row ready, it would issue at the next edge
        check_status(1'b0);
        flush();
        check_status(1'b0);
        retire(2);
        for (int k = 0; k < 8; k++) begin
            check_status(1'b0);
            tick();
        end
        report_test("freeze and flush");

        $display("tests 6, checks %0d, errors %0d", checks, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== regfile.sv ====
/* scalar register file */

`timescale 1ns/10ps
`default_nettype none

`include "issue_defs.svh"

module regfile (
    input logic   CLK,
    input logic   nRST,
    regfile_if.rf rf
);

    localparam int NREGS = 1 << `ISSUE_REG_ADDR_W;

    logic [`ISSUE_WORD_W-1:0] regs [NREGS];
    // read address matches a live write this cycle
    logic                     byp1;
    logic                     byp2;

    // x0 is never written, it stays at its reset value
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen && rf.wsel != '0) begin
            regs[rf.wsel] <= rf.wdata;
        end
    end

    assign byp1 = rf.wen && (rf.wsel == rf.rsel1);
    assign byp2 = rf.wen && (rf.wsel == rf.rsel2);

    // combinational reads
    // x0 reads zero even against a write to it
    always_comb begin
        if (rf.rsel1 == '0) begin
            rf.rdat1 = '0;
        end else if (byp1) begin
            rf.rdat1 = rf.wdata;
        end else begin
            rf.rdat1 = regs[rf.rsel1];
        end

        if (rf.rsel2 == '0) begin
            rf.rdat2 = '0;
        end else if (byp2) begin
            rf.rdat2 = rf.wdata;
        end else begin
            rf.rdat2 = regs[rf.rsel2];
        end
    end

endmodule

`default_nettype wire
